/* source/mem_filter_defs.svh */
// seed record filter parameters
// group size, window depth and record field widths

`ifndef MEM_FILTER_DEFS_SVH
`define MEM_FILTER_DEFS_SVH

// records emitted per group
`define MF_GRP_SIZE 3

// window depth, one extra slot for the record that breaks the group
`define MF_ROWS (`MF_GRP_SIZE + 1)

// slot index width, covers 0 .. MF_ROWS-1
`define MF_CNT_W $clog2(`MF_ROWS)

// query and reference position width
`define MF_POS_W 32

// seed score width
`define MF_SCORE_W 32

`endif

/* source/mem_filter_pkg.sv */
// seed record filter types
// one record and one decoded window read

`include "mem_filter_defs.svh"

package mem_filter_pkg;

    // one seed, i = query pos, j = reference pos, s = score
    typedef struct packed {
        logic [`MF_POS_W-1:0]   i;
        logic [`MF_POS_W-1:0]   j;
        logic [`MF_SCORE_W-1:0] s;
    } work_mem_t;

    // window read port result
    // empty set when the slot score is zero
    typedef struct packed {
        work_mem_t rec;
        logic      empty;
    } slot_t;

endpackage

/* source/record_window.sv */
// record window for the seed filter
// shift history of the last MF_ROWS records with group clear and indexed read

`timescale 1ns/1ps
`include "mem_filter_defs.svh"

module record_window (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      accept,
    input  logic                      restart,
    input  logic                      clear_group,
    input  mem_filter_pkg::work_mem_t in_rec,
    input  logic [`MF_CNT_W-1:0]      rd_idx,
    output mem_filter_pkg::slot_t     rd_slot
);

    // slot 0 newest, slot MF_ROWS-1 oldest
    mem_filter_pkg::work_mem_t slots [`MF_ROWS];

    // new record enters slot 0 and older slots move up on accept
    // group slots are zeroed after a group has gone out
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            for (int k = 0; k < `MF_ROWS; k++) begin
                slots[k] <= '0;
            end
        end else if (accept) begin
            slots[0] <= in_rec;
            for (int k = 1; k < `MF_ROWS; k++) begin
                slots[k] <= slots[k-1];
            end
        end else if (clear_group) begin
            // slot 0 stays as the start of the next group
            for (int k = 1; k < `MF_ROWS; k++) begin
                slots[k] <= '0;
            end
        end
    end

    // indexed read
    // zero score means nothing stored there
    always_comb begin
        rd_slot.rec   = slots[rd_idx];
        rd_slot.empty = (slots[rd_idx].s == '0);
    end

endmodule

/* source/group_break_detect.sv */
// group boundary detector for the seed filter
// flags a record whose i and j both differ from the previous record

`timescale 1ns/1ps
`include "mem_filter_defs.svh"

module group_break_detect (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      accept,
    input  logic                      restart,
    input  mem_filter_pkg::work_mem_t in_rec,
    output logic                      group_break
);

    // key of the last accepted record
    logic [`MF_POS_W-1:0] last_i;
    logic [`MF_POS_W-1:0] last_j;

    // both coordinates have to move for a new group
    logic key_moved;

    assign key_moved = (in_rec.i != last_i) && (in_rec.j != last_j);

    // key register, zero key at the start of every run
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            last_i <= '0;
            last_j <= '0;
        end else if (accept) begin
            last_i <= in_rec.i;
            last_j <= in_rec.j;
        end
    end

    // registered at acceptance
    // holds until the next accept, read by the sequencer in judge
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            group_break <= 1'b0;
        end else if (accept) begin
            group_break <= key_moved;
        end
    end

endmodule

/* source/emit_sequencer.sv */
// emission sequencer for the seed filter
// FSM for input acceptance, group output, window clear, flush and finish

`timescale 1ns/1ps
`include "mem_filter_defs.svh"

module emit_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      stop,
    input  logic                      group_break,
    input  mem_filter_pkg::slot_t     rd_slot,
    output logic                      in_ready,
    output logic                      accept,
    output logic                      restart,
    output logic                      clear_group,
    output logic [`MF_CNT_W-1:0]      rd_idx,
    output mem_filter_pkg::work_mem_t out_rec,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      finish,
    output logic                      busy,
    input  logic                      in_valid
);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_wait   = 3'd1;
    localparam logic [2:0] st_judge  = 3'd2;
    localparam logic [2:0] st_output = 3'd3;
    localparam logic [2:0] st_clear  = 3'd4;
    localparam logic [2:0] st_flush  = 3'd5;

    // group output walks oldest slot down to 1, flush walks MF_ROWS-2 down to 0
    localparam logic [`MF_CNT_W-1:0] idx_out_first   = `MF_ROWS - 1;
    localparam logic [`MF_CNT_W-1:0] idx_out_last    = 1;
    localparam logic [`MF_CNT_W-1:0] idx_flush_first = `MF_ROWS - 2;
    localparam logic [`MF_CNT_W-1:0] idx_flush_last  = 0;

    logic [2:0] state;
    logic [2:0] nxt_state;
    logic       stop_latched;
    logic       emitting;
    logic       slot_done;
    logic       go_flush;

    // handshakes and strobes to the window
    assign in_ready    = (state == st_wait);
    assign accept      = in_ready && in_valid;
    assign restart     = (state == st_idle) && start;
    assign clear_group = (state == st_clear);
    assign busy        = (state != st_idle);

    // current slot goes straight to the output
    // window is frozen while emitting so out_rec holds under back-pressure
    assign emitting  = (state == st_output) || (state == st_flush);
    assign out_rec   = rd_slot.rec;
    assign out_valid = emitting && !rd_slot.empty;

    // empty slot costs one cycle, full slot waits for its handshake
    assign slot_done = rd_slot.empty || out_ready;

    // flush only when no record is taken this cycle
    assign go_flush = (state == st_wait) && !accept && stop_latched;

    // stop request latch
    always_ff @(posedge clk) begin
        if (rst) begin
            stop_latched <= 1'b0;
        end else if (go_flush) begin
            stop_latched <= 1'b0;
        end else if (stop) begin
            stop_latched <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    nxt_state = st_wait;
                end
            end
            st_wait: begin
                if (accept) begin
                    nxt_state = st_judge;
                end else if (stop_latched) begin
                    nxt_state = st_flush;
                end
            end
            // group_break valid here, one cycle after acceptance
            st_judge: begin
                if (group_break) begin
                    nxt_state = st_output;
                end else begin
                    nxt_state = st_wait;
                end
            end
            st_output: begin
                if (slot_done && rd_idx == idx_out_last) begin
                    nxt_state = st_clear;
                end
            end
            st_clear: begin
                nxt_state = st_wait;
            end
            st_flush: begin
                if (slot_done && rd_idx == idx_flush_last) begin
                    nxt_state = st_idle;
                end
            end
            default: begin
                nxt_state = st_idle;
            end
        endcase
    end

    // slot counter
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_idx <= '0;
        end else if (state == st_judge && group_break) begin
            rd_idx <= idx_out_first;
        end else if (go_flush) begin
            rd_idx <= idx_flush_first;
        end else if (emitting && slot_done && rd_idx != '0) begin
            rd_idx <= rd_idx - 1'b1;
        end
    end

    // one cycle pulse after the last flush slot
    always_ff @(posedge clk) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= (state == st_flush) && slot_done && (rd_idx == idx_flush_last);
        end
    end

endmodule

/* source/mem_filter_top.sv */
// seed record stream filter
// emits each finished group of window slots oldest first and flushes on stop

`timescale 1ns/1ps
`include "mem_filter_defs.svh"

module mem_filter_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      stop,
    input  mem_filter_pkg::work_mem_t in_rec,
    input  logic                      in_valid,
    output logic                      in_ready,
    output mem_filter_pkg::work_mem_t out_rec,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      finish,
    output logic                      busy
);

    logic                    accept;
    logic                    restart;
    logic                    clear_group;
    logic                    group_break;
    logic [`MF_CNT_W-1:0]    rd_idx;
    mem_filter_pkg::slot_t   rd_slot;

    // history of recent records
    record_window record_window_inst (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .restart     (restart),
        .clear_group (clear_group),
        .in_rec      (in_rec),
        .rd_idx      (rd_idx),
        .rd_slot     (rd_slot)
    );

    // key compare in parallel with the window shift
    group_break_detect group_break_detect_inst (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .restart     (restart),
        .in_rec      (in_rec),
        .group_break (group_break)
    );

    emit_sequencer emit_sequencer_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .stop        (stop),
        .group_break (group_break),
        .rd_slot     (rd_slot),
        .in_ready    (in_ready),
        .accept      (accept),
        .restart     (restart),
        .clear_group (clear_group),
        .rd_idx      (rd_idx),
        .out_rec     (out_rec),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .finish      (finish),
        .busy        (busy),
        .in_valid    (in_valid)
    );

endmodule

/* tests/mem_filter_assertions.sv */
// handshake checks for the seed record filter
// bound onto the top level, reports through failing assertions

`timescale 1ns/1ps

module mem_filter_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input mem_filter_pkg::work_mem_t out_rec,
    input logic                      finish
);

    // stalled output keeps valid and record
    property out_hold_p;
        @(posedge clk) disable iff (rst)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_rec));
    endproperty

    // finish is a one cycle pulse
    property finish_pulse_p;
        @(posedge clk) disable iff (rst)
            finish |=> !finish;
    endproperty

    // input phase and output phase never overlap
    property no_overlap_p;
        @(posedge clk) disable iff (rst)
            !(in_ready && out_valid);
    endproperty

    out_hold_a: assert property (out_hold_p)
        else $error("out_valid dropped or out_rec changed while out_ready was low");

    finish_pulse_a: assert property (finish_pulse_p)
        else $error("finish stayed high for two cycles");

    no_overlap_a: assert property (no_overlap_p)
        else $error("in_ready and out_valid high in the same cycle");

endmodule

bind mem_filter_top mem_filter_assertions mem_filter_assertions_inst (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rec   (out_rec),
    .finish    (finish)
);

/* tests/mem_filter_tb.sv */
// testbench for the seed record filter
// random records and back-pressure checked against a window model

`timescale 1ns/1ps
`include "mem_filter_defs.svh"

module mem_filter_tb;

    localparam int step_timeout = 200;
    localparam int run_len      = 60;

    logic                      clk;
    logic                      rst;
    logic                      start;
    logic                      stop;
    mem_filter_pkg::work_mem_t in_rec;
    logic                      in_valid;
    logic                      in_ready;
    mem_filter_pkg::work_mem_t out_rec;
    logic                      out_valid;
    logic                      out_ready;
    logic                      finish;
    logic                      busy;

    // model window with slot 0 newest
    mem_filter_pkg::work_mem_t model_win [`MF_ROWS];
    // records the DUT still owes in order
    mem_filter_pkg::work_mem_t exp_q [$];

    logic [31:0] rng;
    logic [31:0] ready_rng;
    int          errors;
    int          checks;
    int          out_count;
    int          finish_count;
    int          base;
    string       test_name;

    mem_filter_top mem_filter_top_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stop      (stop),
        .in_rec    (in_rec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_rec   (out_rec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .finish    (finish),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // stimulus stream
    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic mem_filter_pkg::work_mem_t make_record(input int i, input int j,
                                                              input int s);
        mem_filter_pkg::work_mem_t rec;
        rec.i = i;
        rec.j = j;
        rec.s = s;
        return rec;
    endfunction

    // small position range so keys repeat often
    // about one score in five is zero
    function automatic mem_filter_pkg::work_mem_t random_record();
        mem_filter_pkg::work_mem_t rec;
        logic [31:0]               r;
        rec.i = next_rand() % 4;
        rec.j = next_rand() % 4;
        r     = next_rand();
        rec.s = (r % 5 == 0) ? 32'd0 : (r >> 8) + 32'd1;
        return rec;
    endfunction

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reset_model();
        for (int k = 0; k < `MF_ROWS; k++) begin
            model_win[k] = '0;
        end
    endtask

    // new record breaks the group when both i and j move away from slot 0
    task automatic predict_accept(input mem_filter_pkg::work_mem_t rec);
        logic brk;
        brk = (rec.i != model_win[0].i) && (rec.j != model_win[0].j);
        for (int k = `MF_ROWS - 1; k > 0; k--) begin
            model_win[k] = model_win[k-1];
        end
        model_win[0] = rec;
        if (brk) begin
            // previous group oldest first with empties skipped
            for (int k = `MF_ROWS - 1; k > 0; k--) begin
                if (model_win[k].s != '0) begin
                    exp_q.push_back(model_win[k]);
                end
            end
            for (int k = 1; k < `MF_ROWS; k++) begin
                model_win[k] = '0;
            end
        end
    endtask

    task automatic predict_flush();
        for (int k = `MF_ROWS - 2; k >= 0; k--) begin
            if (model_win[k].s != '0) begin
                exp_q.push_back(model_win[k]);
            end
        end
    endtask

    // called on a rising edge and returns on the edge of the transfer
    task automatic send_record(input mem_filter_pkg::work_mem_t rec);
        int waited;
        waited = 0;
        in_rec   <= rec;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready && waited < step_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            errors++;
            $display("%s: timed out waiting for in_ready", test_name);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_input_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < step_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            errors++;
            $display("%s: filter never came back to accept input", test_name);
        end
        #1;
    endtask

    task automatic start_run();
        @(posedge clk);
        start <= 1'b1;
        reset_model();
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value({test_name, " busy"}, 96'd1, busy);
        @(posedge clk);
    endtask

    // stop goes out only once input is idle so the model window is final
    task automatic finish_run();
        int waited;
        int finish_before;
        waited        = 0;
        finish_before = finish_count;
        stop <= 1'b1;
        predict_flush();
        @(posedge clk);
        stop <= 1'b0;
        @(negedge clk);
        while (!finish && waited < step_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!finish) begin
            errors++;
            $display("%s: timed out waiting for finish", test_name);
        end
        // a second pulse would show in these quiet cycles
        repeat (4) @(negedge clk);
        #1;
        check_value({test_name, " finish pulses"}, 96'd1, finish_count - finish_before);
        check_value({test_name, " busy"}, 96'd0, busy);
        check_value({test_name, " pending outputs"}, 96'd0, exp_q.size());
        @(posedge clk);
    endtask

    // accepted records feed the model
    always @(negedge clk) begin
        if (!rst && in_valid && in_ready) begin
            predict_accept(in_rec);
        end
    end

    // output handshakes in order against the queue
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: output record %h arrived with none expected", test_name, out_rec);
            end else begin
                check_value({test_name, " out_rec"}, exp_q.pop_front(), out_rec);
            end
            assert (out_rec.s != '0) else begin
                errors++;
                $display("CHECK FAILED %s out score expected nonzero actual %h",
                         test_name, out_rec.s);
            end
        end
        if (!rst && finish) begin
            finish_count++;
        end
    end

    // back-pressure low about a third of the time
    always @(posedge clk) begin
        out_ready <= (ready_rng % 3 != 0);
        ready_rng <= xorshift32(ready_rng);
    end

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        stop         = 1'b0;
        in_rec       = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        rng          = 32'd94770;
        ready_rng    = xorshift32(32'd94770);
        errors       = 0;
        checks       = 0;
        out_count    = 0;
        finish_count = 0;
        test_name    = "reset";
        reset_model();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset in_ready", 96'd0, in_ready);
        check_value("reset out_valid", 96'd0, out_valid);
        check_value("reset finish", 96'd0, finish);
        check_value("reset busy", 96'd0, busy);
        @(posedge clk);

        test_name = "start";
        start_run();
        test_name = "random_run1";
        repeat (run_len) begin
            send_record(random_record());
            repeat (next_rand() % 3) @(posedge clk);
        end
        // known tail leaves full slots and key 3,3 behind for the restart
        test_name = "stale_tail";
        send_record(make_record(3, 3, 9));
        send_record(make_record(3, 1, 8));
        send_record(make_record(3, 3, 6));
        test_name = "flush_run1";
        finish_run();

        // second run starts from an empty window and a zero key
        test_name = "restart";
        start_run();
        test_name = "empty_group";
        base = out_count;
        // same i as the zero key so no break
        send_record(make_record(0, 2, 5));
        // break where only the record above goes out
        send_record(make_record(1, 1, 0));
        send_record(make_record(1, 2, 0));
        send_record(make_record(1, 3, 0));
        // break on an all empty group
        send_record(make_record(2, 0, 7));
        wait_input_ready();
        check_value({test_name, " outputs"}, 96'd1, out_count - base);
        @(posedge clk);

        test_name = "random_run2";
        repeat (run_len) begin
            send_record(random_record());
            repeat (next_rand() % 3) @(posedge clk);
        end
        test_name = "flush_run2";
        finish_run();

        if (out_count == 0) begin
            errors++;
            $display("no output records were seen during the run");
        end
        $display("errors %0d checks %0d outputs %0d finish pulses %0d",
                 errors, checks, out_count, finish_count);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/mem_filter_pkg.sv
source/record_window.sv
source/group_break_detect.sv
source/emit_sequencer.sv
source/mem_filter_top.sv
tests/mem_filter_assertions.sv
tests/mem_filter_tb.sv
